// ==== include/pl_shell_macros.svh ====
`ifndef PL_SHELL_MACROS_SVH
`define PL_SHELL_MACROS_SVH

// ------------------------------------------------------------
// bus geometry
// ------------------------------------------------------------
// axi4-lite data bus width
`define PLS_DATA_W 32
// byte address width, covers eight word slots
`define PLS_ADDR_W 5
// byte offset bits below the word index
`define PLS_ADDR_LSB 2
// word index width
`define PLS_IDX_W 3

// ------------------------------------------------------------
// shell contents
// ------------------------------------------------------------
`define PLS_NUM_CSR 2
// ps_to_pl fifos, written by the bus
`define PLS_NUM_IN 1
// pl_to_ps fifos, read by the bus
`define PLS_NUM_OUT 1
`define PLS_FIFO_DEPTH 4
// holds 0 to depth inclusive
`define PLS_CNT_W 3

`endif

// ==== hdl/pl_shell_pkg.sv ====
`include "pl_shell_macros.svh"

package pl_shell_pkg;

   // one bus data word
   typedef logic [`PLS_DATA_W-1:0] word_t;

   // write request from the write port, valid for one cycle
   typedef struct packed {
      logic                  v;
      logic [`PLS_IDX_W-1:0] idx;
      word_t                 data;
   } wr_req_t;

   // read request from the read port, valid for one cycle
   typedef struct packed {
      logic                  v;
      logic [`PLS_IDX_W-1:0] idx;
   } rd_req_t;

   // aw/w/b channel states
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ACCEPT,
      WR_RESP
   } wr_state_e;

   // ar/r channel states
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ACCEPT,
      RD_DATA
   } rd_state_e;

   // regions of the read map, in address order
   typedef enum logic [2:0] {
      RGN_CSR,
      RGN_OUT_DATA,
      RGN_OUT_COUNT,
      RGN_IN_COUNT,
      RGN_NONE
   } rd_region_e;

endpackage

// ==== hdl/counted_fifo.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module counted_fifo
#(
   // 1: count_o gives free slots, 0: stored elements
   parameter bit count_free = 1'b0
)
(
   input  logic                    S_AXI_ACLK,
   input  logic                    S_AXI_ARESETN,
   input  logic                    push_i,
   input  logic [`PLS_DATA_W-1:0]  data_i,
   output logic                    full_o,
   input  logic                    pop_i,
   output logic [`PLS_DATA_W-1:0]  data_o,
   output logic                    empty_o,
   output logic [`PLS_CNT_W-1:0]   count_o
);

   // pointer wraps naturally, depth is a power of two
   localparam int unsigned ptr_w = $clog2(`PLS_FIFO_DEPTH);

   logic [`PLS_DATA_W-1:0] mem_r [`PLS_FIFO_DEPTH];
   logic [ptr_w-1:0]       wr_ptr_r;
   logic [ptr_w-1:0]       rd_ptr_r;
   logic [`PLS_CNT_W-1:0]  used_r;
   logic                   do_push;
   logic                   do_pop;

   assign full_o  = (used_r == `PLS_CNT_W'(`PLS_FIFO_DEPTH));
   assign empty_o = (used_r == '0);

   // dropped when it would overflow or underflow
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // ------------------------------------------------------------
   // storage and pointers
   // ------------------------------------------------------------
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (do_push)
         mem_r[wr_ptr_r] <= data_i;
   end

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         used_r   <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (do_pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         // occupancy moves on the same edge as push or pop
         case ({do_push, do_pop})
            2'b10:   used_r <= used_r + 1'b1;
            2'b01:   used_r <= used_r - 1'b1;
            default: used_r <= used_r;
         endcase
      end
   end

   // head word, undefined when empty
   assign data_o = mem_r[rd_ptr_r];

   // free slots or stored elements
   assign count_o = count_free ? (`PLS_CNT_W'(`PLS_FIFO_DEPTH) - used_r) : used_r;

   // producer must respect full
   a_push_full: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      push_i |-> !full_o)
      else $error("push while full");

   // consumer must respect empty
   a_pop_empty: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      pop_i |-> !empty_o)
      else $error("pop while empty");

endmodule

// ==== hdl/axil_write_port.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module axil_write_port
(
   input  logic                         S_AXI_ACLK,
   input  logic                         S_AXI_ARESETN,
   input  logic [`PLS_ADDR_W-1:0]       awaddr_i,
   input  logic                         awvalid_i,
   input  pl_shell_pkg::word_t          wdata_i,
   input  logic                         wvalid_i,
   input  logic                         bready_i,
   output logic                         awready_o,
   output logic                         wready_o,
   output logic                         bvalid_o,
   output logic [1:0]                   bresp_o,
   output pl_shell_pkg::wr_req_t        wr_req_o
);

   pl_shell_pkg::wr_state_e state_r;
   pl_shell_pkg::wr_state_e state_n;
   logic [`PLS_IDX_W-1:0]   idx_r;
   pl_shell_pkg::word_t     data_r;
   logic                    take_w;

   // address and data are taken together and only from idle
   assign take_w = (state_r == pl_shell_pkg::WR_IDLE) && awvalid_i && wvalid_i;

   // ------------------------------------------------------------
   // state machine
   // ------------------------------------------------------------
   always_comb
   begin
      state_n = state_r;
      case (state_r)
         pl_shell_pkg::WR_IDLE:
         begin
            if (take_w)
               state_n = pl_shell_pkg::WR_ACCEPT;
         end
         // ready pulse cycle where the write commits at its closing edge
         pl_shell_pkg::WR_ACCEPT:
            state_n = pl_shell_pkg::WR_RESP;
         // hold bvalid until the master takes it
         pl_shell_pkg::WR_RESP:
         begin
            if (bready_i)
               state_n = pl_shell_pkg::WR_IDLE;
         end
         default:
            state_n = pl_shell_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         state_r <= pl_shell_pkg::WR_IDLE;
      else
         state_r <= state_n;
   end

   // word index and payload captured at the sampling edge
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (take_w)
      begin
         idx_r  <= awaddr_i[`PLS_ADDR_W-1:`PLS_ADDR_LSB];
         data_r <= wdata_i;
      end
   end

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------
   assign awready_o = (state_r == pl_shell_pkg::WR_ACCEPT);
   assign wready_o  = (state_r == pl_shell_pkg::WR_ACCEPT);
   assign bvalid_o  = (state_r == pl_shell_pkg::WR_RESP);
   // always okay
   assign bresp_o   = 2'b00;

   // one request per transaction in the ready cycle
   assign wr_req_o = '{v: awready_o, idx: idx_r, data: data_r};

   // response must not be withdrawn before the master takes it
   a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      bvalid_o && !bready_i |=> bvalid_o)
      else $error("bvalid dropped without bready");

endmodule

// ==== hdl/axil_read_port.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module axil_read_port
(
   input  logic                         S_AXI_ACLK,
   input  logic                         S_AXI_ARESETN,
   input  logic [`PLS_ADDR_W-1:0]       araddr_i,
   input  logic                         arvalid_i,
   input  logic                         rready_i,
   output logic                         arready_o,
   output logic                         rvalid_o,
   output pl_shell_pkg::word_t          rdata_o,
   output logic [1:0]                   rresp_o,
   output pl_shell_pkg::rd_req_t        rd_req_o,
   input  pl_shell_pkg::word_t          rd_word_i
);

   pl_shell_pkg::rd_state_e state_r;
   pl_shell_pkg::rd_state_e state_n;
   logic [`PLS_IDX_W-1:0]   idx_r;
   logic                    take_ar;

   // a new address is only taken with no read data pending
   assign take_ar = (state_r == pl_shell_pkg::RD_IDLE) && arvalid_i;

   // ------------------------------------------------------------
   // state machine
   // ------------------------------------------------------------
   always_comb
   begin
      state_n = state_r;
      case (state_r)
         pl_shell_pkg::RD_IDLE:
         begin
            if (take_ar)
               state_n = pl_shell_pkg::RD_ACCEPT;
         end
         // request goes out, word gets registered at the closing edge
         pl_shell_pkg::RD_ACCEPT:
            state_n = pl_shell_pkg::RD_DATA;
         pl_shell_pkg::RD_DATA:
         begin
            if (rready_i)
               state_n = pl_shell_pkg::RD_IDLE;
         end
         default:
            state_n = pl_shell_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         state_r <= pl_shell_pkg::RD_IDLE;
      else
         state_r <= state_n;
   end

   // word index latched at the sampling edge
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (take_ar)
         idx_r <= araddr_i[`PLS_ADDR_W-1:`PLS_ADDR_LSB];
   end

   // returned word held until rready
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (state_r == pl_shell_pkg::RD_ACCEPT)
         rdata_o <= rd_word_i;
   end

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------
   assign arready_o = (state_r == pl_shell_pkg::RD_ACCEPT);
   assign rvalid_o  = (state_r == pl_shell_pkg::RD_DATA);
   assign rresp_o   = 2'b00;
   // single cycle request, so a head read pops exactly once
   assign rd_req_o  = '{v: arready_o, idx: idx_r};

   // read data frozen while the master stalls
   a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
      else $error("rdata changed under back-pressure");

endmodule

// ==== hdl/shell_regmap.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module shell_regmap
(
   input  logic                                    S_AXI_ACLK,
   input  logic                                    S_AXI_ARESETN,
   input  pl_shell_pkg::wr_req_t                   wr_req_i,
   input  pl_shell_pkg::rd_req_t                   rd_req_i,
   output pl_shell_pkg::word_t                     rd_word_o,
   output pl_shell_pkg::word_t [`PLS_NUM_CSR-1:0]  csr_data_o,
   output pl_shell_pkg::word_t                     ps_to_pl_data_o,
   output logic                                    ps_to_pl_v_o,
   input  logic                                    ps_to_pl_yumi_i,
   input  pl_shell_pkg::word_t                     pl_to_ps_data_i,
   input  logic                                    pl_to_ps_v_i,
   output logic                                    pl_to_ps_ready_o
);

   // read map bases in word indices
   localparam int unsigned out_data_base  = `PLS_NUM_CSR;
   localparam int unsigned out_count_base = out_data_base + `PLS_NUM_OUT;
   localparam int unsigned in_count_base  = out_count_base + `PLS_NUM_OUT;
   localparam int unsigned rd_end         = in_count_base + `PLS_NUM_IN;
   // write map has the fifo data right after the csrs
   localparam int unsigned wr_end         = `PLS_NUM_CSR + `PLS_NUM_IN;
   localparam int unsigned csr_idx_w      = (`PLS_NUM_CSR > 1) ? $clog2(`PLS_NUM_CSR) : 1;

   pl_shell_pkg::rd_region_e              rd_rgn;
   pl_shell_pkg::word_t [`PLS_NUM_CSR-1:0] csr_r;
   logic                                  wr_csr;
   logic                                  wr_in;
   logic                                  rd_head;
   logic                                  in_full;
   logic                                  in_empty;
   logic [`PLS_CNT_W-1:0]                 in_count;
   logic                                  out_full;
   logic                                  out_empty;
   logic [`PLS_CNT_W-1:0]                 out_count;
   pl_shell_pkg::word_t                   out_head;

   // ------------------------------------------------------------
   // decode
   // ------------------------------------------------------------
   assign wr_csr = wr_req_i.v && (wr_req_i.idx < `PLS_NUM_CSR);
   // indices past the fifo slot are ignored
   assign wr_in  = wr_req_i.v && (wr_req_i.idx >= `PLS_NUM_CSR) && (wr_req_i.idx < wr_end);

   always_comb
   begin
      if (rd_req_i.idx < out_data_base)
         rd_rgn = pl_shell_pkg::RGN_CSR;
      else if (rd_req_i.idx < out_count_base)
         rd_rgn = pl_shell_pkg::RGN_OUT_DATA;
      else if (rd_req_i.idx < in_count_base)
         rd_rgn = pl_shell_pkg::RGN_OUT_COUNT;
      else if (rd_req_i.idx < rd_end)
         rd_rgn = pl_shell_pkg::RGN_IN_COUNT;
      else
         rd_rgn = pl_shell_pkg::RGN_NONE;
   end

   assign rd_head = rd_req_i.v && (rd_rgn == pl_shell_pkg::RGN_OUT_DATA);

   // ------------------------------------------------------------
   // user csrs
   // ------------------------------------------------------------
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         csr_r <= '0;
      else if (wr_csr)
         csr_r[wr_req_i.idx[csr_idx_w-1:0]] <= wr_req_i.data;
   end

   assign csr_data_o = csr_r;

   // ------------------------------------------------------------
   // fifos
   // ------------------------------------------------------------
   // ps_to_pl fifo counts free slots and drops a push when full
   counted_fifo #(.count_free(1'b1)) u_in_fifo
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .push_i        (wr_in),
      .data_i        (wr_req_i.data),
      .full_o        (in_full),
      .pop_i         (ps_to_pl_yumi_i),
      .data_o        (ps_to_pl_data_o),
      .empty_o       (in_empty),
      .count_o       (in_count)
   );

   assign ps_to_pl_v_o = !in_empty;

   // pl_to_ps fifo counts stored elements and a head read pops only when not empty
   counted_fifo #(.count_free(1'b0)) u_out_fifo
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .push_i        (pl_to_ps_v_i && !out_full),
      .data_i        (pl_to_ps_data_i),
      .full_o        (out_full),
      .pop_i         (rd_head && !out_empty),
      .data_o        (out_head),
      .empty_o       (out_empty),
      .count_o       (out_count)
   );

   assign pl_to_ps_ready_o = !out_full;

   // ------------------------------------------------------------
   // read data in the same cycle as the request
   // ------------------------------------------------------------
   always_comb
   begin
      case (rd_rgn)
         pl_shell_pkg::RGN_CSR:       rd_word_o = csr_r[rd_req_i.idx[csr_idx_w-1:0]];
         pl_shell_pkg::RGN_OUT_DATA:  rd_word_o = out_head;
         pl_shell_pkg::RGN_OUT_COUNT: rd_word_o = pl_shell_pkg::word_t'(out_count);
         pl_shell_pkg::RGN_IN_COUNT:  rd_word_o = pl_shell_pkg::word_t'(in_count);
         default:                     rd_word_o = '0;
      endcase
   end

   // software overran the ps_to_pl fifo and the word is dropped
   a_wr_full: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      wr_in |-> !in_full)
      else $error("bus write to full ps_to_pl fifo");

   // head read of an empty fifo returns garbage
   a_rd_empty: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      rd_head |-> !out_empty)
      else $error("bus read from empty pl_to_ps fifo");

endmodule

// ==== hdl/zynq_pl_shell.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module zynq_pl_shell
(
   input  logic                                    S_AXI_ACLK,
   input  logic                                    S_AXI_ARESETN,
   // write address, data and response
   input  logic [`PLS_ADDR_W-1:0]                  S_AXI_AWADDR,
   input  logic                                    S_AXI_AWVALID,
   output logic                                    S_AXI_AWREADY,
   input  pl_shell_pkg::word_t                     S_AXI_WDATA,
   input  logic                                    S_AXI_WVALID,
   output logic                                    S_AXI_WREADY,
   output logic [1:0]                              S_AXI_BRESP,
   output logic                                    S_AXI_BVALID,
   input  logic                                    S_AXI_BREADY,
   // read address and data
   input  logic [`PLS_ADDR_W-1:0]                  S_AXI_ARADDR,
   input  logic                                    S_AXI_ARVALID,
   output logic                                    S_AXI_ARREADY,
   output pl_shell_pkg::word_t                     S_AXI_RDATA,
   output logic [1:0]                              S_AXI_RRESP,
   output logic                                    S_AXI_RVALID,
   input  logic                                    S_AXI_RREADY,
   // logic side
   output pl_shell_pkg::word_t [`PLS_NUM_CSR-1:0]  csr_data_o,
   output pl_shell_pkg::word_t                     ps_to_pl_data_o,
   output logic                                    ps_to_pl_v_o,
   input  logic                                    ps_to_pl_yumi_i,
   input  pl_shell_pkg::word_t                     pl_to_ps_data_i,
   input  logic                                    pl_to_ps_v_i,
   output logic                                    pl_to_ps_ready_o
);

   pl_shell_pkg::wr_req_t wr_req;
   pl_shell_pkg::rd_req_t rd_req;
   pl_shell_pkg::word_t   rd_word;

   // ------------------------------------------------------------
   // bus ports, side by side
   // ------------------------------------------------------------
   axil_write_port u_wr_port
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .awaddr_i      (S_AXI_AWADDR),
      .awvalid_i     (S_AXI_AWVALID),
      .wdata_i       (S_AXI_WDATA),
      .wvalid_i      (S_AXI_WVALID),
      .bready_i      (S_AXI_BREADY),
      .awready_o     (S_AXI_AWREADY),
      .wready_o      (S_AXI_WREADY),
      .bvalid_o      (S_AXI_BVALID),
      .bresp_o       (S_AXI_BRESP),
      .wr_req_o      (wr_req)
   );

   axil_read_port u_rd_port
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .araddr_i      (S_AXI_ARADDR),
      .arvalid_i     (S_AXI_ARVALID),
      .rready_i      (S_AXI_RREADY),
      .arready_o     (S_AXI_ARREADY),
      .rvalid_o      (S_AXI_RVALID),
      .rdata_o       (S_AXI_RDATA),
      .rresp_o       (S_AXI_RRESP),
      .rd_req_o      (rd_req),
      .rd_word_i     (rd_word)
   );

   // csrs, fifos and read mux
   shell_regmap u_regmap
   (
      .S_AXI_ACLK       (S_AXI_ACLK),
      .S_AXI_ARESETN    (S_AXI_ARESETN),
      .wr_req_i         (wr_req),
      .rd_req_i         (rd_req),
      .rd_word_o        (rd_word),
      .csr_data_o       (csr_data_o),
      .ps_to_pl_data_o  (ps_to_pl_data_o),
      .ps_to_pl_v_o     (ps_to_pl_v_o),
      .ps_to_pl_yumi_i  (ps_to_pl_yumi_i),
      .pl_to_ps_data_i  (pl_to_ps_data_i),
      .pl_to_ps_v_i     (pl_to_ps_v_i),
      .pl_to_ps_ready_o (pl_to_ps_ready_o)
   );

endmodule

// ==== dv/tb_zynq_pl_shell.sv ====
`timescale 1ns/10ps
`include "pl_shell_macros.svh"

module tb_zynq_pl_shell;

   // 40 ns clock
   localparam int unsigned half_period = 20;
   // the directed tests need about 120 cycles
   localparam int unsigned timeout_cycles = 2000;

   // byte addresses of the register map
   localparam logic [`PLS_ADDR_W-1:0] csr0_addr      = 5'h00;
   localparam logic [`PLS_ADDR_W-1:0] csr1_addr      = 5'h04;
   localparam logic [`PLS_ADDR_W-1:0] out_data_addr  = 5'h08;
   localparam logic [`PLS_ADDR_W-1:0] in_data_addr   = 5'h08;
   localparam logic [`PLS_ADDR_W-1:0] out_count_addr = 5'h0C;
   localparam logic [`PLS_ADDR_W-1:0] in_count_addr  = 5'h10;
   localparam logic [`PLS_ADDR_W-1:0] unused_addr    = 5'h18;

   logic                                   S_AXI_ACLK;
   logic                                   S_AXI_ARESETN;
   logic [`PLS_ADDR_W-1:0]                 awaddr;
   logic                                   awvalid;
   logic                                   awready;
   pl_shell_pkg::word_t                    wdata;
   logic                                   wvalid;
   logic                                   wready;
   logic [1:0]                             bresp;
   logic                                   bvalid;
   logic                                   bready;
   logic [`PLS_ADDR_W-1:0]                 araddr;
   logic                                   arvalid;
   logic                                   arready;
   pl_shell_pkg::word_t                    rdata;
   logic [1:0]                             rresp;
   logic                                   rvalid;
   logic                                   rready;
   pl_shell_pkg::word_t [`PLS_NUM_CSR-1:0] csr_data;
   pl_shell_pkg::word_t                    ps_to_pl_data;
   logic                                   ps_to_pl_v;
   logic                                   ps_to_pl_yumi;
   pl_shell_pkg::word_t                    pl_to_ps_data;
   logic                                   pl_to_ps_v;
   logic                                   pl_to_ps_ready;

   logic [31:0] lfsr_state;
   int unsigned n_checks;
   int unsigned n_errors;
   int unsigned cycles;

   zynq_pl_shell u_zynq_pl_shell
   (
      .S_AXI_ACLK       (S_AXI_ACLK),
      .S_AXI_ARESETN    (S_AXI_ARESETN),
      .S_AXI_AWADDR     (awaddr),
      .S_AXI_AWVALID    (awvalid),
      .S_AXI_AWREADY    (awready),
      .S_AXI_WDATA      (wdata),
      .S_AXI_WVALID     (wvalid),
      .S_AXI_WREADY     (wready),
      .S_AXI_BRESP      (bresp),
      .S_AXI_BVALID     (bvalid),
      .S_AXI_BREADY     (bready),
      .S_AXI_ARADDR     (araddr),
      .S_AXI_ARVALID    (arvalid),
      .S_AXI_ARREADY    (arready),
      .S_AXI_RDATA      (rdata),
      .S_AXI_RRESP      (rresp),
      .S_AXI_RVALID     (rvalid),
      .S_AXI_RREADY     (rready),
      .csr_data_o       (csr_data),
      .ps_to_pl_data_o  (ps_to_pl_data),
      .ps_to_pl_v_o     (ps_to_pl_v),
      .ps_to_pl_yumi_i  (ps_to_pl_yumi),
      .pl_to_ps_data_i  (pl_to_ps_data),
      .pl_to_ps_v_i     (pl_to_ps_v),
      .pl_to_ps_ready_o (pl_to_ps_ready)
   );

   initial
   begin
      S_AXI_ACLK = 1'b0;
      forever #(half_period) S_AXI_ACLK = ~S_AXI_ACLK;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   // x^32 + x^22 + x^2 + x + 1 shifted left with feedback into bit 0
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one lfsr step per bit of the word
   task automatic rand_word(output pl_shell_pkg::word_t w);
      w = '0;
      for (int i = 0; i < `PLS_DATA_W; i++)
      begin
         lfsr_state = next_lfsr(lfsr_state);
         w = {w[`PLS_DATA_W-2:0], lfsr_state[0]};
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
         n_errors++;
      end
   endtask

   // full write with bready held high
   // lat counts edges from drive to bvalid
   task automatic axi_write(input logic [`PLS_ADDR_W-1:0] addr,
                            input pl_shell_pkg::word_t data,
                            output logic [1:0] resp, output int lat);
      @(negedge S_AXI_ACLK);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      lat     = 0;
      while (!awready)
      begin
         @(negedge S_AXI_ACLK);
         lat++;
      end
      check_val("S_AXI_WREADY", wready, 1'b1);
      // address and data transfer at the next edge
      @(negedge S_AXI_ACLK);
      lat++;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid)
      begin
         @(negedge S_AXI_ACLK);
         lat++;
      end
      resp = bresp;
      @(negedge S_AXI_ACLK);
      bready = 1'b0;
   endtask

   // full read with rready held high
   task automatic axi_read(input logic [`PLS_ADDR_W-1:0] addr,
                           output pl_shell_pkg::word_t data,
                           output logic [1:0] resp, output int lat);
      @(negedge S_AXI_ACLK);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      lat     = 0;
      while (!arready)
      begin
         @(negedge S_AXI_ACLK);
         lat++;
      end
      @(negedge S_AXI_ACLK);
      lat++;
      arvalid = 1'b0;
      while (!rvalid)
      begin
         @(negedge S_AXI_ACLK);
         lat++;
      end
      data = rdata;
      resp = rresp;
      @(negedge S_AXI_ACLK);
      rready = 1'b0;
   endtask

   // logic side push that waits for room
   task automatic pl_push(input pl_shell_pkg::word_t data);
      @(negedge S_AXI_ACLK);
      while (!pl_to_ps_ready)
         @(negedge S_AXI_ACLK);
      pl_to_ps_data = data;
      pl_to_ps_v    = 1'b1;
      @(negedge S_AXI_ACLK);
      pl_to_ps_v = 1'b0;
   endtask

   // read and compare in one go
   task automatic read_expect(input logic [`PLS_ADDR_W-1:0] addr,
                              input pl_shell_pkg::word_t exp);
      pl_shell_pkg::word_t got;
      logic [1:0]          resp;
      int                  lat;
      axi_read(addr, got, resp, lat);
      check_val("S_AXI_RDATA", got, exp);
      check_val("S_AXI_RRESP", resp, 2'b00);
   endtask

   // ------------------------------------------------------------
   // tests
   // ------------------------------------------------------------
   task automatic after_reset();
      check_val("S_AXI_AWREADY", awready, 1'b0);
      check_val("S_AXI_WREADY", wready, 1'b0);
      check_val("S_AXI_BVALID", bvalid, 1'b0);
      check_val("S_AXI_ARREADY", arready, 1'b0);
      check_val("S_AXI_RVALID", rvalid, 1'b0);
      check_val("csr_data_o[0]", csr_data[0], '0);
      check_val("csr_data_o[1]", csr_data[1], '0);
      check_val("ps_to_pl_v_o", ps_to_pl_v, 1'b0);
      check_val("pl_to_ps_ready_o", pl_to_ps_ready, 1'b1);
      // empty in fifo shows all slots free
      read_expect(in_count_addr, `PLS_FIFO_DEPTH);
      read_expect(out_count_addr, 0);
   endtask

   task automatic csr_path();
      pl_shell_pkg::word_t d0;
      pl_shell_pkg::word_t d1;
      logic [1:0]          resp;
      int                  lat;
      rand_word(d0);
      rand_word(d1);
      axi_write(csr0_addr, d0, resp, lat);
      check_val("S_AXI_BRESP", resp, 2'b00);
      check_val("csr_data_o[0]", csr_data[0], d0);
      axi_write(csr1_addr, d1, resp, lat);
      check_val("S_AXI_BRESP", resp, 2'b00);
      check_val("csr_data_o[1]", csr_data[1], d1);
      read_expect(csr0_addr, d0);
      read_expect(csr1_addr, d1);
      read_expect(unused_addr, 0);
   endtask

   task automatic ps_to_pl_fifo();
      pl_shell_pkg::word_t words [3];
      logic [1:0]          resp;
      int                  lat;
      for (int i = 0; i < 3; i++)
      begin
         rand_word(words[i]);
         axi_write(in_data_addr, words[i], resp, lat);
      end
      read_expect(in_count_addr, `PLS_FIFO_DEPTH - 3);
      // head pops at the edge where yumi is high
      for (int i = 0; i < 3; i++)
      begin
         check_val("ps_to_pl_v_o", ps_to_pl_v, 1'b1);
         check_val("ps_to_pl_data_o", ps_to_pl_data, words[i]);
         ps_to_pl_yumi = 1'b1;
         @(negedge S_AXI_ACLK);
         ps_to_pl_yumi = 1'b0;
      end
      check_val("ps_to_pl_v_o", ps_to_pl_v, 1'b0);
      read_expect(in_count_addr, `PLS_FIFO_DEPTH);
   endtask

   task automatic pl_to_ps_fifo();
      pl_shell_pkg::word_t words [3];
      for (int i = 0; i < 3; i++)
      begin
         rand_word(words[i]);
         pl_push(words[i]);
      end
      read_expect(out_count_addr, 3);
      // each head read pops one word
      for (int i = 0; i < 3; i++)
         read_expect(out_data_addr, words[i]);
      read_expect(out_count_addr, 0);
   endtask

   task automatic back_pressure();
      pl_shell_pkg::word_t d0;
      pl_shell_pkg::word_t d1;
      pl_shell_pkg::word_t held;
      rand_word(d0);
      rand_word(d1);
      // first write with the response stalled
      @(negedge S_AXI_ACLK);
      awaddr  = csr0_addr;
      wdata   = d0;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b0;
      while (!awready)
         @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      // second write queued behind the pending response
      awaddr = csr1_addr;
      wdata  = d1;
      repeat (5)
      begin
         check_val("S_AXI_BVALID", bvalid, 1'b1);
         check_val("S_AXI_AWREADY", awready, 1'b0);
         check_val("S_AXI_WREADY", wready, 1'b0);
         @(negedge S_AXI_ACLK);
      end
      bready = 1'b1;
      while (!awready)
         @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid)
         @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      bready = 1'b0;
      check_val("csr_data_o[0]", csr_data[0], d0);
      check_val("csr_data_o[1]", csr_data[1], d1);

      // read with rready low and a second read waiting
      araddr  = csr0_addr;
      arvalid = 1'b1;
      rready  = 1'b0;
      while (!arready)
         @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      araddr = csr1_addr;
      held   = rdata;
      check_val("S_AXI_RDATA", held, d0);
      repeat (5)
      begin
         check_val("S_AXI_RVALID", rvalid, 1'b1);
         check_val("S_AXI_RDATA", rdata, held);
         check_val("S_AXI_ARREADY", arready, 1'b0);
         @(negedge S_AXI_ACLK);
      end
      rready = 1'b1;
      while (!arready)
         @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      arvalid = 1'b0;
      check_val("S_AXI_RVALID", rvalid, 1'b1);
      check_val("S_AXI_RDATA", rdata, d1);
      @(negedge S_AXI_ACLK);
      rready = 1'b0;
   endtask

   // two edges from sampled valid to the response
   task automatic latency();
      pl_shell_pkg::word_t d;
      pl_shell_pkg::word_t got;
      logic [1:0]          resp;
      int                  lat;
      rand_word(d);
      axi_write(csr1_addr, d, resp, lat);
      check_val("BVALID latency", lat, 2);
      axi_read(csr1_addr, got, resp, lat);
      check_val("RVALID latency", lat, 2);
      check_val("S_AXI_RDATA", got, d);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial
   begin
      S_AXI_ARESETN = 1'b0;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wvalid        = 1'b0;
      bready        = 1'b0;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b0;
      ps_to_pl_yumi = 1'b0;
      pl_to_ps_data = '0;
      pl_to_ps_v    = 1'b0;
      lfsr_state    = 32'h975e;
      n_checks      = 0;
      n_errors      = 0;
      repeat (5)
         @(negedge S_AXI_ACLK);
      S_AXI_ARESETN = 1'b1;
      @(negedge S_AXI_ACLK);

      after_reset();
      csr_path();
      ps_to_pl_fifo();
      pl_to_ps_fifo();
      back_pressure();
      latency();

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // watchdog that ends the run when a handshake never completes
   initial
   begin
      cycles = 0;
      while (cycles < timeout_cycles)
      begin
         @(posedge S_AXI_ACLK);
         cycles++;
      end
      $display("timeout after %0d cycles, a bus handshake never completed", cycles);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/pl_shell_pkg.sv
hdl/counted_fifo.sv
hdl/axil_write_port.sv
hdl/axil_read_port.sv
hdl/shell_regmap.sv
hdl/zynq_pl_shell.sv
dv/tb_zynq_pl_shell.sv

// ==== Bender.yml ====
package:
  name: zynq_pl_shell

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/pl_shell_pkg.sv
      - hdl/counted_fifo.sv
      - hdl/axil_write_port.sv
      - hdl/axil_read_port.sv
      - hdl/shell_regmap.sv
      - hdl/zynq_pl_shell.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_zynq_pl_shell.sv
